// ==== cabac_ulow_refine.f ====
src/cabac_ulow_pkg.sv
src/ulow_slot_refine.sv
src/ulow_carry_chain.sv
src/ulow_string_pack.sv
src/ulow_zero_locate.sv
src/cabac_ulow_refine.sv
dv/cabac_ulow_refine_props.sv
dv/tb_cabac_ulow_refine.sv

// ==== dv/cabac_ulow_refine_props.sv ====
// Concurrent checks on the output register of the low-register update step.
// Bound into every cabac_ulow_refine instance.

`timescale 1ns/1ps
`default_nettype none

module cabac_ulow_refine_props #(
    parameter int num_slots = cabac_ulow_pkg::def_num_slots,
    parameter int slot_bits = cabac_ulow_pkg::def_slot_bits
) (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                active,
    input logic                                update,
    input logic [cabac_ulow_pkg::len_bits-1:0] length,
    input logic                                carry_out,
    input logic [num_slots*slot_bits-1:0]      low_bits,
    input logic [cabac_ulow_pkg::len_bits-1:0] zero_pos
);

    clear_to_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !active |=> (length == '0 && !carry_out && low_bits == '0 && zero_pos == '0))
        else $error("outputs not cleared after active low");

    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (active && !update) |=> ($stable(length) && $stable(carry_out)
                                 && $stable(low_bits) && $stable(zero_pos)))
        else $error("outputs changed while update low");

    zero_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(zero_pos) <= num_slots * slot_bits)
        else $error("zero_pos beyond string width");

endmodule

bind cabac_ulow_refine cabac_ulow_refine_props #(
    .num_slots (num_slots),
    .slot_bits (slot_bits)
) props0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .active    (active),
    .update    (update),
    .length    (length),
    .carry_out (carry_out),
    .low_bits  (low_bits),
    .zero_pos  (zero_pos)
);

`default_nettype wire

// ==== dv/tb_cabac_ulow_refine.sv ====
// Testbench for the CABAC low-register update step.
// Reads one vector per line from dv/ulow_stimulus.txt, drives it at a rising edge
// and checks the registered outputs one cycle later against the expected columns.
// Hold and clear lines carry the values the outputs must show after the edge.

`timescale 1ns/1ps
`default_nettype none

module tb_cabac_ulow_refine;

    localparam int str_bits = cabac_ulow_pkg::def_num_slots * cabac_ulow_pkg::def_slot_bits;
    localparam int max_lines = 1000;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  active;
    logic                                  update;
    logic [cabac_ulow_pkg::count_bits-1:0] in_number;
    logic [14:0]                           shift;
    logic [4:0]                            overflow;
    logic [str_bits-1:0]                   buffer;
    logic [cabac_ulow_pkg::len_bits-1:0]   length;
    logic                                  carry_out;
    logic [str_bits-1:0]                   low_bits;
    logic [cabac_ulow_pkg::len_bits-1:0]   zero_pos;

    int mismatches;
    int other_errors;

    cabac_ulow_refine dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .active    (active),
        .update    (update),
        .in_number (in_number),
        .shift     (shift),
        .overflow  (overflow),
        .buffer    (buffer),
        .length    (length),
        .carry_out (carry_out),
        .low_bits  (low_bits),
        .zero_pos  (zero_pos)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_outputs(input int line_no, input int exp_len, input int exp_cy,
                                 input logic [str_bits-1:0] exp_low, input int exp_zero);
        assert (length == exp_len[cabac_ulow_pkg::len_bits-1:0])
        else
        begin
            $display("MISMATCH t=%0t line %0d length %0d expected %0d",
                     $time, line_no, length, exp_len);
            mismatches++;
        end
        assert (carry_out == exp_cy[0])
        else
        begin
            $display("MISMATCH t=%0t line %0d carry_out %0b expected %0b",
                     $time, line_no, carry_out, exp_cy[0]);
            mismatches++;
        end
        assert (low_bits == exp_low)
        else
        begin
            $display("MISMATCH t=%0t line %0d low_bits %h expected %h",
                     $time, line_no, low_bits, exp_low);
            mismatches++;
        end
        assert (zero_pos == exp_zero[cabac_ulow_pkg::len_bits-1:0])
        else
        begin
            $display("MISMATCH t=%0t line %0d zero_pos %0d expected %0d",
                     $time, line_no, zero_pos, exp_zero);
            mismatches++;
        end
    endtask

    task automatic run_vectors();
        int fd;
        int rc;
        int line_no;
        int v_act;
        int v_upd;
        int v_num;
        int e_len;
        int e_cy;
        int e_zero;
        string text;
        logic [2:0] s4;
        logic [2:0] s3;
        logic [2:0] s2;
        logic [2:0] s1;
        logic [2:0] s0;
        logic [4:0] ov;
        logic [6:0] b4;
        logic [6:0] b3;
        logic [6:0] b2;
        logic [6:0] b1;
        logic [6:0] b0;
        logic [str_bits-1:0] e_low;

        fd = $fopen("dv/ulow_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("error: cannot open stimulus file dv/ulow_stimulus.txt");
            other_errors++;
            return;
        end
        for (line_no = 1; line_no <= max_lines; line_no++)
        begin
            if ($fgets(text, fd) == 0)
                break;
            if (text.len() < 2 || text.getc(0) == "#")
                continue;
            rc = $sscanf(text, "%d %d %d %d %d %d %d %d %b %h %h %h %h %h %d %d %h %d",
                         v_act, v_upd, v_num, s4, s3, s2, s1, s0, ov,
                         b4, b3, b2, b1, b0, e_len, e_cy, e_low, e_zero);
            if (rc != 18)
            begin
                $display("error: stimulus line %0d is malformed, %0d fields read", line_no, rc);
                other_errors++;
                continue;
            end
            @(posedge clk);
            active    <= v_act[0];
            update    <= v_upd[0];
            in_number <= v_num[cabac_ulow_pkg::count_bits-1:0];
            shift     <= {s4, s3, s2, s1, s0};
            overflow  <= ov;
            buffer    <= {b4, b3, b2, b1, b0};
            @(posedge clk);  // DUT takes the vector here
            @(negedge clk);
            check_outputs(line_no, e_len, e_cy, e_low, e_zero);
        end
        $fclose(fd);
    endtask

    initial
    begin
        mismatches   = 0;
        other_errors = 0;
        rst_n        = 1'b0;
        active       = 1'b0;
        update       = 1'b0;
        in_number    = '0;
        shift        = '0;
        overflow     = '0;
        buffer       = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_outputs(0, 0, 0, '0, 0);  // all zero out of reset
        run_vectors();
        $display("summary: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/ulow_stimulus.txt ====
# act upd num s4 s3 s2 s1 s0 ovf(b4..b0) buf4 buf3 buf2 buf1 buf0 (hex)
# exp_len exp_carry exp_low_bits(hex, 35 bits) exp_zero_pos
1 1 1 0 0 0 0 3 00000 00 00 00 00 55 3 0 5ffffffff 2
1 1 2 0 0 0 7 2 00000 00 00 00 2a 40 9 0 4abffffff 9
1 1 3 0 0 6 0 0 00000 00 00 2c 00 00 6 0 2dfffffff 6
1 1 4 0 7 7 7 7 00000 00 55 00 7e 01 28 0 01fc02aff 27
1 1 5 5 7 4 0 1 00000 12 7f 30 00 00 17 0 1bf93ffff 17
1 1 3 0 0 4 2 3 00100 00 00 00 60 20 9 0 303ffffff 9
1 1 2 0 0 0 3 2 00010 00 00 00 50 7f 5 1 17fffffff 4
1 1 1 0 0 0 0 4 00011 00 00 00 00 70 4 1 77fffffff 4
1 1 0 3 3 3 3 3 11111 7f 7f 7f 7f 7f 0 0 7ffffffff 0
1 0 1 0 0 0 0 3 00000 00 00 00 00 55 0 0 7ffffffff 0
0 1 2 0 0 0 7 2 00000 00 00 00 2a 40 0 0 000000000 0
1 0 5 5 7 4 0 1 00000 12 7f 30 00 00 0 0 000000000 0
1 1 2 0 0 0 7 2 00000 00 00 00 2a 40 9 0 4abffffff 9
1 0 3 0 0 4 2 3 00100 00 00 00 60 20 9 0 4abffffff 9
0 0 3 0 0 4 2 3 00100 00 00 00 60 20 0 0 000000000 0
1 1 3 0 0 4 2 3 00100 00 00 00 60 20 9 0 303ffffff 9

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --timing \
    --top-module tb_cabac_ulow_refine \
    -Mdir obj_dir \
    -f cabac_ulow_refine.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_cabac_ulow_refine > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

// ==== src/cabac_ulow_pkg.sv ====
// Field widths and default slot geometry for the CABAC low-register update step.
// The RTL and the bound checks refer to these by scoped name.
// The defaults give five slots of seven bits, which is a 35-bit update string.

`default_nettype none

package cabac_ulow_pkg;

    // one slot's shift field, 0 to 7 bits leaving the low register
    localparam int shift_bits = 3;

    // default slot geometry, overridden only from the top level
    localparam int def_num_slots = 5;
    localparam int def_slot_bits = 7;

    // active slot count, 0 to def_num_slots
    localparam int count_bits = 3;

    // total length and zero position, up to 35
    localparam int len_bits = 6;

endpackage

`default_nettype wire

// ==== src/cabac_ulow_refine.sv ====
// Low-register update step of the CABAC arithmetic encoder.
// Merges up to num_slots bin results per cycle into one update string with its
// length, carry out and lowest-zero position, one cycle after the inputs.
// active low clears the outputs at the next edge and wins over update.
// update low holds the outputs.

`timescale 1ns/1ps
`default_nettype none

module cabac_ulow_refine #(
    parameter int num_slots = cabac_ulow_pkg::def_num_slots,
    parameter int slot_bits = cabac_ulow_pkg::def_slot_bits
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            active,
    input  logic                                            update,
    input  logic [cabac_ulow_pkg::count_bits-1:0]           in_number,
    input  logic [num_slots*cabac_ulow_pkg::shift_bits-1:0] shift,
    input  logic [num_slots-1:0]                            overflow,
    input  logic [num_slots*slot_bits-1:0]                  buffer,
    output logic [cabac_ulow_pkg::len_bits-1:0]             length,
    output logic                                            carry_out,
    output logic [num_slots*slot_bits-1:0]                  low_bits,
    output logic [cabac_ulow_pkg::len_bits-1:0]             zero_pos
);

    localparam int sb = cabac_ulow_pkg::shift_bits;

    logic [num_slots-1:0]                saturated;
    logic [num_slots-1:0]                carry_in;
    logic [num_slots*slot_bits-1:0]      refined;
    logic [num_slots*slot_bits-1:0]      next_low_bits;
    logic [cabac_ulow_pkg::len_bits-1:0] next_length;
    logic [cabac_ulow_pkg::len_bits-1:0] next_zero_pos;
    logic                                next_carry;

    for (genvar g = 0; g < num_slots; g++)
    begin : g_slot
        ulow_slot_refine #(
            .slot_bits (slot_bits)
        ) u_slot (
            .shift     (shift[g*sb +: sb]),
            .buffer    (buffer[g*slot_bits +: slot_bits]),
            .carry_in  (carry_in[g]),
            .refined   (refined[g*slot_bits +: slot_bits]),
            .saturated (saturated[g])
        );
    end

    ulow_carry_chain #(
        .num_slots (num_slots)
    ) u_chain (
        .in_number (in_number),
        .overflow  (overflow),
        .saturated (saturated),
        .carry_in  (carry_in),
        .carry_out (next_carry)
    );

    ulow_string_pack #(
        .num_slots (num_slots),
        .slot_bits (slot_bits)
    ) u_pack (
        .in_number (in_number),
        .shift     (shift),
        .refined   (refined),
        .length    (next_length),
        .low_bits  (next_low_bits)
    );

    ulow_zero_locate #(
        .num_slots (num_slots),
        .slot_bits (slot_bits)
    ) u_zero (
        .low_bits (next_low_bits),
        .zero_pos (next_zero_pos)
    );

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            length    <= '0;
            carry_out <= 1'b0;
            low_bits  <= '0;
            zero_pos  <= '0;
        end
        else if (!active)  // sync clear
        begin
            length    <= '0;
            carry_out <= 1'b0;
            low_bits  <= '0;
            zero_pos  <= '0;
        end
        else if (update)
        begin
            length    <= next_length;
            carry_out <= next_carry;
            low_bits  <= next_low_bits;
            zero_pos  <= next_zero_pos;
        end
    end

endmodule

`default_nettype wire

// ==== src/ulow_carry_chain.sv ====
// Carry propagation across the active slots.
// Overflow of a later slot ripples toward slot 0 through saturated slots.
// Slot k receives the chain carry of slot k+1, and the chain carry of slot 0
// leaves as carry_out. Inactive slots neither start nor pass a carry.

`timescale 1ns/1ps
`default_nettype none

module ulow_carry_chain #(
    parameter int num_slots = cabac_ulow_pkg::def_num_slots
) (
    input  logic [cabac_ulow_pkg::count_bits-1:0] in_number,
    input  logic [num_slots-1:0]                  overflow,
    input  logic [num_slots-1:0]                  saturated,
    output logic [num_slots-1:0]                  carry_in,
    output logic                                  carry_out
);

    always_comb
    begin
        logic ripple;

        ripple = 1'b0;  // nothing above the last slot
        for (int k = num_slots - 1; k >= 0; k--)
        begin
            carry_in[k] = ripple;
            if (k < int'(in_number))
            begin
                ripple = overflow[k] | (saturated[k] & ripple);
            end
            else
            begin
                ripple = 1'b0;
            end
        end
        carry_out = ripple;
    end

endmodule

`default_nettype wire

// ==== src/ulow_slot_refine.sv ====
// Refinement of one encoder slot.
// Keeps the top shift bits of the buffer and forces the rest to one.
// A carry from the next slot increments the kept field modulo 2**shift.
// Saturation flags a kept field of all ones, so a carry passes straight through it.

`timescale 1ns/1ps
`default_nettype none

module ulow_slot_refine #(
    parameter int slot_bits = cabac_ulow_pkg::def_slot_bits
) (
    input  logic [cabac_ulow_pkg::shift_bits-1:0] shift,
    input  logic [slot_bits-1:0]                  buffer,
    input  logic                                  carry_in,
    output logic [slot_bits-1:0]                  refined,
    output logic                                  saturated
);

    logic [slot_bits-1:0] keep_mask;  // ones over the kept MSBs
    logic [slot_bits-1:0] kept_lsb;
    logic [slot_bits-1:0] kept_sum;

    always_comb
    begin
        keep_mask = ~({slot_bits{1'b1}} >> shift);

        // lowest set bit of the mask, zero when shift is 0
        kept_lsb = keep_mask & (~keep_mask + 1'b1);

        // wraps out of the top, which gives the modulo
        kept_sum = (buffer & keep_mask) + (carry_in ? kept_lsb : '0);
    end

    assign refined   = kept_sum | ~keep_mask;
    assign saturated = &(buffer | ~keep_mask);  // also true for shift 0

endmodule

`default_nettype wire

// ==== src/ulow_string_pack.sv ====
// Packs the refined slots into the update string, MSB first.
// The string starts as all ones. Each active slot is written at the running sum
// of the shifts below it, so a later slot overwrites the filler ones of the
// slots before it. length is the sum of the active shifts.

`timescale 1ns/1ps
`default_nettype none

module ulow_string_pack #(
    parameter int num_slots = cabac_ulow_pkg::def_num_slots,
    parameter int slot_bits = cabac_ulow_pkg::def_slot_bits
) (
    input  logic [cabac_ulow_pkg::count_bits-1:0]           in_number,
    input  logic [num_slots*cabac_ulow_pkg::shift_bits-1:0] shift,
    input  logic [num_slots*slot_bits-1:0]                  refined,
    output logic [cabac_ulow_pkg::len_bits-1:0]             length,
    output logic [num_slots*slot_bits-1:0]                  low_bits
);

    localparam int str_bits = num_slots * slot_bits;
    localparam int pad_bits = cabac_ulow_pkg::len_bits - cabac_ulow_pkg::shift_bits;

    always_comb
    begin
        logic [cabac_ulow_pkg::len_bits-1:0]   offset;
        logic [cabac_ulow_pkg::shift_bits-1:0] step;

        offset   = '0;
        low_bits = '1;
        for (int k = 0; k < num_slots; k++)
        begin
            step = shift[k*cabac_ulow_pkg::shift_bits +: cabac_ulow_pkg::shift_bits];
            if (k < int'(in_number))
            begin
                // slot MSB sits right after the bits already consumed
                low_bits[str_bits - 1 - int'(offset) -: slot_bits] =
                    refined[k*slot_bits +: slot_bits];
                offset = offset + {{pad_bits{1'b0}}, step};
            end
        end
        length = offset;
    end

endmodule

`default_nettype wire

// ==== src/ulow_zero_locate.sv ====
// Locates the least significant zero of the update string.
// The result counts from the MSB starting at 1 and is 0 for an all-ones string.

`timescale 1ns/1ps
`default_nettype none

module ulow_zero_locate #(
    parameter int num_slots = cabac_ulow_pkg::def_num_slots,
    parameter int slot_bits = cabac_ulow_pkg::def_slot_bits
) (
    input  logic [num_slots*slot_bits-1:0]      low_bits,
    output logic [cabac_ulow_pkg::len_bits-1:0] zero_pos
);

    localparam int str_bits = num_slots * slot_bits;

    always_comb
    begin
        logic [cabac_ulow_pkg::len_bits-1:0] pos;
        logic                                found;

        pos      = '0;
        found    = 1'b0;
        zero_pos = '0;
        for (int i = 0; i < str_bits; i++)  // LSB upward, first zero wins
        begin
            pos = pos + 1'b1;
            if (!found && !low_bits[i])
            begin
                found    = 1'b1;
                zero_pos = pos;
            end
        end
        // pos counted from the LSB, turn it into a position from the MSB
        if (found)
        begin
            zero_pos = pos - zero_pos + 1'b1;
        end
    end

endmodule

`default_nettype wire
